// ==== run.sh ====
#!/bin/sh
# build the store buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f store_buffer.f \
  --top-module tb_store_buffer -o tb_store_buffer
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_store_buffer +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== sb_checker.sv ====
// store buffer protocol checker
// bound into the top level, flags illegal core strobes and an unstable cache request

`include "sb_defs.svh"

module sb_checker (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                                      valid_i,
  input logic                                      commit_i,
  input logic                                      flush_i,
  input logic                                      mem_req_i,
  input logic                                      mem_gnt_i,
  // tag, index, data, byte enables and size of the head write, concatenated
  input logic [`SB_PLEN+`SB_XLEN+sb_pkg::be_w+1:0] mem_fields_i,
  input sb_pkg::sb_spec_cnt_t                      spec_cnt_i,
  input sb_pkg::sb_commit_cnt_t                    commit_cnt_i
);

  import sb_pkg::*;

  localparam sb_spec_cnt_t   spec_full   = sb_spec_cnt_t'(`SB_DEPTH_SPEC);
  localparam sb_commit_cnt_t commit_full = sb_commit_cnt_t'(`SB_DEPTH_COMMIT);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  // the core never commits and flushes in the same cycle
  commit_flush_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(commit_i && flush_i))
    else begin
      $error("commit_i and flush_i high in the same cycle");
      fail_cnt++;
    end

  // a push into a full speculative queue is only legal if a commit frees a slot
  push_not_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> (spec_cnt_i < spec_full) || commit_i)
    else begin
      $error("store pushed while the speculative queue is full");
      fail_cnt++;
    end

  // a commit needs a speculative store to move and room in the commit queue
  commit_legal : assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> (spec_cnt_i != '0) && (commit_cnt_i < commit_full))
    else begin
      $error("commit with an empty speculative queue or a full commit queue");
      fail_cnt++;
    end

  // ----------------------------------------------------------------------
  // cache write port
  // ----------------------------------------------------------------------
  // once raised the request waits for its grant and the write does not change
  req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_fields_i))
    else begin
      $error("mem_req_o dropped or its fields changed before mem_gnt_i");
      fail_cnt++;
    end

endmodule

bind store_buffer sb_checker u_checker (
  .clk_i, .rst_ni, .valid_i, .commit_i, .flush_i, .mem_gnt_i,
  .mem_req_i    (mem_req_o),
  .mem_fields_i ({mem_tag_o, mem_index_o, mem_wdata_o, mem_be_o, mem_size_o}),
  .spec_cnt_i   (u_ctrl.spec_cnt_q),
  .commit_cnt_i (u_ctrl.commit_cnt_q)
);

// ==== sb_commit_queue.sv ====
// non-speculative commit queue
// holds committed stores until the data cache grants them, oldest first

`include "sb_defs.svh"

module sb_commit_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  logic                          pop_i,
  input  sb_pkg::sb_commit_ptr_t        wptr_i,
  input  sb_pkg::sb_commit_ptr_t        rptr_i,
  // entry handed over from the speculative queue
  input  sb_pkg::sb_entry_t             entry_i,
  input  logic [sb_pkg::page_off_w-1:0] page_off_i,
  output logic                          head_valid_o,
  output logic                          match_o,
  // head entry presented to the data cache write port
  output logic [`SB_INDEX_W-1:0]        mem_index_o,
  output logic [`SB_TAG_W-1:0]          mem_tag_o,
  output logic [`SB_XLEN-1:0]           mem_wdata_o,
  output logic [sb_pkg::be_w-1:0]       mem_be_o,
  output logic [1:0]                    mem_size_o
);

  import sb_pkg::*;

  sb_paddr_u                   addr_q [`SB_DEPTH_COMMIT];
  logic [`SB_XLEN-1:0]         data_q [`SB_DEPTH_COMMIT];
  logic [be_w-1:0]             be_q   [`SB_DEPTH_COMMIT];
  logic [1:0]                  size_q [`SB_DEPTH_COMMIT];
  logic [`SB_DEPTH_COMMIT-1:0] valid_q;

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin : payload_wr
    if (push_i) begin
      addr_q[wptr_i] <= entry_i.addr;
      data_q[wptr_i] <= entry_i.data;
      be_q[wptr_i]   <= entry_i.be;
      size_q[wptr_i] <= entry_i.size;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_wr
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      // the head leaves on grant, there is no write response to wait for
      if (pop_i) begin
        valid_q[rptr_i] <= 1'b0;
      end
      // the speculative head is always valid when the core commits it
      if (push_i) begin
        valid_q[wptr_i] <= entry_i.valid;
      end
    end
  end

  // ------------------------------------------------------------------
  // cache write port
  // ------------------------------------------------------------------
  // the head only moves on a pop, so the fields stay put while a request waits
  assign head_valid_o = valid_q[rptr_i];
  assign mem_index_o  = addr_q[rptr_i].cache.index;
  assign mem_tag_o    = addr_q[rptr_i].cache.tag;
  assign mem_wdata_o  = data_q[rptr_i];
  assign mem_be_o     = be_q[rptr_i];
  assign mem_size_o   = size_q[rptr_i];

  // ------------------------------------------------------------------
  // page offset check
  // ------------------------------------------------------------------
  always_comb begin : offset_match
    match_o = 1'b0;
    // any valid committed store in the same double word makes the load wait
    for (int unsigned i = 0; i < `SB_DEPTH_COMMIT; i++) begin
      if (valid_q[i] && (addr_q[i].page.page_off[page_off_w-1:match_lsb] ==
                         page_off_i[page_off_w-1:match_lsb])) begin
        match_o = 1'b1;
      end
    end
  end

endmodule

// ==== sb_ctrl.sv ====
// store buffer controller
// owns all queue pointers and occupancy counters and runs the cache drain handshake

`include "sb_defs.svh"

module sb_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // strobes and levels from the load/store unit
  input  logic                   valid_i,
  input  logic                   commit_i,
  input  logic                   flush_i,
  input  logic                   stall_i,
  // grant from the data cache and head status from the commit queue
  input  logic                   mem_gnt_i,
  input  logic                   head_valid_i,
  // enables for the two queues
  output logic                   spec_push_o,
  output logic                   spec_pop_o,
  output logic                   spec_flush_o,
  output logic                   commit_push_o,
  output logic                   commit_pop_o,
  output logic                   mem_req_o,
  // queue pointers
  output sb_pkg::sb_spec_ptr_t   spec_wptr_o,
  output sb_pkg::sb_spec_ptr_t   spec_rptr_o,
  output sb_pkg::sb_commit_ptr_t commit_wptr_o,
  output sb_pkg::sb_commit_ptr_t commit_rptr_o,
  // status towards the core
  output logic                   ready_o,
  output logic                   commit_ready_o,
  output logic                   no_st_pending_o,
  output logic                   empty_o
);

  import sb_pkg::*;

  localparam sb_spec_cnt_t   spec_depth   = sb_spec_cnt_t'(`SB_DEPTH_SPEC);
  localparam sb_commit_cnt_t commit_depth = sb_commit_cnt_t'(`SB_DEPTH_COMMIT);

  sb_spec_ptr_t   spec_wptr_q, spec_wptr_n;
  sb_spec_ptr_t   spec_rptr_q, spec_rptr_n;
  sb_spec_cnt_t   spec_cnt_q, spec_cnt_n;
  sb_commit_ptr_t commit_wptr_q, commit_wptr_n;
  sb_commit_ptr_t commit_rptr_q, commit_rptr_n;
  sb_commit_cnt_t commit_cnt_q, commit_cnt_n;

  // ------------------------------------------------------------------
  // queue enables
  // ------------------------------------------------------------------
  // a commit pops the speculative head and pushes it into the commit queue
  assign spec_push_o   = valid_i;
  assign spec_pop_o    = commit_i;
  assign spec_flush_o  = flush_i;
  assign commit_push_o = commit_i;

  // the head is offered to the cache as soon as it is valid, unless the core stalls us
  assign mem_req_o    = head_valid_i & ~stall_i;
  // a write counts as done on grant, there is no response to wait for
  assign commit_pop_o = mem_req_o & mem_gnt_i;

  // ------------------------------------------------------------------
  // speculative side
  // ------------------------------------------------------------------
  always_comb begin : spec_next
    spec_wptr_n = spec_wptr_q + sb_spec_ptr_t'(spec_push_o);
    spec_rptr_n = spec_rptr_q + sb_spec_ptr_t'(spec_pop_o);
    spec_cnt_n  = spec_cnt_q + sb_spec_cnt_t'(spec_push_o) - sb_spec_cnt_t'(spec_pop_o);
    // flush drops everything not yet committed, commit never comes with it
    if (spec_flush_o) begin
      spec_wptr_n = spec_rptr_q;
      spec_cnt_n  = '0;
    end
  end

  // ready looks one edge ahead, a commit in this cycle always frees a slot
  assign ready_o = (spec_cnt_n < spec_depth) || commit_i;

  // ------------------------------------------------------------------
  // commit side
  // ------------------------------------------------------------------
  always_comb begin : commit_next
    commit_wptr_n = commit_wptr_q + sb_commit_ptr_t'(commit_push_o);
    commit_rptr_n = commit_rptr_q + sb_commit_ptr_t'(commit_pop_o);
    commit_cnt_n  = commit_cnt_q + sb_commit_cnt_t'(commit_push_o)
                  - sb_commit_cnt_t'(commit_pop_o);
  end

  assign commit_ready_o  = commit_cnt_q < commit_depth;
  // nothing left that is committed but not yet written to the cache
  assign no_st_pending_o = commit_cnt_q == '0;
  assign empty_o         = (spec_cnt_q == '0) && no_st_pending_o;

  assign spec_wptr_o   = spec_wptr_q;
  assign spec_rptr_o   = spec_rptr_q;
  assign commit_wptr_o = commit_wptr_q;
  assign commit_rptr_o = commit_rptr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
    if (!rst_ni) begin
      spec_wptr_q   <= '0;
      spec_rptr_q   <= '0;
      spec_cnt_q    <= '0;
      commit_wptr_q <= '0;
      commit_rptr_q <= '0;
      commit_cnt_q  <= '0;
    end else begin
      spec_wptr_q   <= spec_wptr_n;
      spec_rptr_q   <= spec_rptr_n;
      spec_cnt_q    <= spec_cnt_n;
      commit_wptr_q <= commit_wptr_n;
      commit_rptr_q <= commit_rptr_n;
      commit_cnt_q  <= commit_cnt_n;
    end
  end

endmodule

// ==== sb_defs.svh ====
// store buffer sizing constants
// widths of the physical address, the store data and both queues

`ifndef SB_DEFS_SVH
`define SB_DEFS_SVH

// physical address width, split below into cache tag and index
`define SB_PLEN 34

// store data width, one byte enable per byte
`define SB_XLEN 64

// number of entries in the speculative queue (power of two)
`define SB_DEPTH_SPEC 4

// number of entries in the non-speculative commit queue (power of two)
`define SB_DEPTH_COMMIT 4

// data cache address split, tag and index together cover the full address
`define SB_INDEX_W 12
`define SB_TAG_W 22

`endif

// ==== sb_pkg.sv ====
// store buffer types
// address views, queue entry layout and pointer/counter widths

`include "sb_defs.svh"

package sb_pkg;

  // a page is 4 KiB, so the low 12 address bits are the page offset
  localparam int unsigned page_off_w = 12;
  localparam int unsigned page_num_w = `SB_PLEN - page_off_w;
  localparam int unsigned be_w       = `SB_XLEN / 8;
  // loads are checked at double-word granularity, offset bits below this are ignored
  localparam int unsigned match_lsb  = 3;

  localparam int unsigned spec_ptr_w   = $clog2(`SB_DEPTH_SPEC);
  localparam int unsigned commit_ptr_w = $clog2(`SB_DEPTH_COMMIT);

  // the address as the data cache sees it
  typedef struct packed {
    logic [`SB_TAG_W-1:0]   tag;
    logic [`SB_INDEX_W-1:0] index;
  } sb_cache_addr_t;

  // the same address as the MMU sees it, the offset is identical in VA and PA
  typedef struct packed {
    logic [page_num_w-1:0] page_num;
    logic [page_off_w-1:0] page_off;
  } sb_page_addr_t;

  typedef union packed {
    sb_cache_addr_t cache;
    sb_page_addr_t  page;
  } sb_paddr_u;

  // one buffered store
  typedef struct packed {
    sb_paddr_u           addr;
    logic [`SB_XLEN-1:0] data;
    logic [be_w-1:0]     be;
    logic [1:0]          size;
    logic                valid;
  } sb_entry_t;

  // counters carry one extra bit so that a full queue is distinguishable from empty
  typedef logic [spec_ptr_w-1:0]   sb_spec_ptr_t;
  typedef logic [spec_ptr_w:0]     sb_spec_cnt_t;
  typedef logic [commit_ptr_w-1:0] sb_commit_ptr_t;
  typedef logic [commit_ptr_w:0]   sb_commit_cnt_t;

endpackage

// ==== sb_spec_queue.sv ====
// speculative store queue
// holds uncommitted stores and checks them against the page offset of a load

`include "sb_defs.svh"

module sb_spec_queue (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               push_i,
  input  logic                               pop_i,
  input  logic                               flush_i,
  input  sb_pkg::sb_spec_ptr_t               wptr_i,
  input  sb_pkg::sb_spec_ptr_t               rptr_i,
  // store being placed into the queue
  input  sb_pkg::sb_paddr_u                  paddr_i,
  input  logic [`SB_XLEN-1:0]                data_i,
  input  logic [sb_pkg::be_w-1:0]            be_i,
  input  logic [1:0]                         size_i,
  // load offset check
  input  logic [sb_pkg::page_off_w-1:0]      page_off_i,
  input  logic                               valid_nf_i,
  output sb_pkg::sb_entry_t                  head_o,
  output logic                               match_o
);

  import sb_pkg::*;

  // payload storage, only the valid bits carry meaning after reset
  sb_paddr_u                addr_q [`SB_DEPTH_SPEC];
  logic [`SB_XLEN-1:0]      data_q [`SB_DEPTH_SPEC];
  logic [be_w-1:0]          be_q   [`SB_DEPTH_SPEC];
  logic [1:0]               size_q [`SB_DEPTH_SPEC];
  logic [`SB_DEPTH_SPEC-1:0] valid_q;

  always_ff @(posedge clk_i) begin : payload_wr
    if (push_i) begin
      addr_q[wptr_i] <= paddr_i;
      data_q[wptr_i] <= data_i;
      be_q[wptr_i]   <= be_i;
      size_q[wptr_i] <= size_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_wr
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else begin
      if (pop_i) begin
        valid_q[rptr_i] <= 1'b0;
      end
      // placed after the pop so a push into the slot being freed keeps its valid bit
      if (push_i) begin
        valid_q[wptr_i] <= 1'b1;
      end
    end
  end

  // oldest speculative store, copied into the commit queue on commit
  assign head_o = '{addr:  addr_q[rptr_i],
                    data:  data_q[rptr_i],
                    be:    be_q[rptr_i],
                    size:  size_q[rptr_i],
                    valid: valid_q[rptr_i]};

  // ------------------------------------------------------------------
  // page offset check
  // ------------------------------------------------------------------
  always_comb begin : offset_match
    // the store entering this cycle is not registered yet but must still block the load
    match_o = valid_nf_i &&
              (paddr_i.page.page_off[page_off_w-1:match_lsb] ==
               page_off_i[page_off_w-1:match_lsb]);
    for (int unsigned i = 0; i < `SB_DEPTH_SPEC; i++) begin
      if (valid_q[i] && (addr_q[i].page.page_off[page_off_w-1:match_lsb] ==
                         page_off_i[page_off_w-1:match_lsb])) begin
        match_o = 1'b1;
      end
    end
  end

endmodule

// ==== store_buffer.f ====
+incdir+.
sb_pkg.sv
sb_ctrl.sv
sb_spec_queue.sv
sb_commit_queue.sv
store_buffer.sv
sb_checker.sv
tb_store_buffer.sv

// ==== store_buffer.sv ====
// two-stage store buffer for the load/store unit
// speculative stores are committed into a queue that drains to the data cache

`include "sb_defs.svh"

module store_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // core side
  input  logic                          valid_i,
  input  logic                          commit_i,
  input  logic                          flush_i,
  input  logic                          stall_i,
  input  sb_pkg::sb_paddr_u             paddr_i,
  input  logic [`SB_XLEN-1:0]           data_i,
  input  logic [sb_pkg::be_w-1:0]       be_i,
  input  logic [1:0]                    size_i,
  output logic                          ready_o,
  output logic                          commit_ready_o,
  output logic                          no_st_pending_o,
  output logic                          empty_o,
  // load offset check
  input  logic [sb_pkg::page_off_w-1:0] page_off_i,
  input  logic                          valid_nf_i,
  output logic                          page_match_o,
  // data cache write port
  input  logic                          mem_gnt_i,
  output logic                          mem_req_o,
  output logic [`SB_INDEX_W-1:0]        mem_index_o,
  output logic [`SB_TAG_W-1:0]          mem_tag_o,
  output logic [`SB_XLEN-1:0]           mem_wdata_o,
  output logic [sb_pkg::be_w-1:0]       mem_be_o,
  output logic [1:0]                    mem_size_o
);

  import sb_pkg::*;

  logic           spec_push, spec_pop, spec_flush;
  logic           commit_push, commit_pop, head_valid;
  logic           spec_match, commit_match;
  sb_spec_ptr_t   spec_wptr, spec_rptr;
  sb_commit_ptr_t commit_wptr, commit_rptr;
  sb_entry_t      spec_head;

  sb_ctrl u_ctrl (
    .clk_i, .rst_ni, .valid_i, .commit_i, .flush_i, .stall_i, .mem_gnt_i,
    .head_valid_i    (head_valid),
    .spec_push_o     (spec_push),
    .spec_pop_o      (spec_pop),
    .spec_flush_o    (spec_flush),
    .commit_push_o   (commit_push),
    .commit_pop_o    (commit_pop),
    .mem_req_o,
    .spec_wptr_o     (spec_wptr),
    .spec_rptr_o     (spec_rptr),
    .commit_wptr_o   (commit_wptr),
    .commit_rptr_o   (commit_rptr),
    .ready_o, .commit_ready_o, .no_st_pending_o, .empty_o
  );

  sb_spec_queue u_spec_queue (
    .clk_i, .rst_ni,
    .push_i  (spec_push),
    .pop_i   (spec_pop),
    .flush_i (spec_flush),
    .wptr_i  (spec_wptr),
    .rptr_i  (spec_rptr),
    .paddr_i, .data_i, .be_i, .size_i, .page_off_i, .valid_nf_i,
    .head_o  (spec_head),
    .match_o (spec_match)
  );

  sb_commit_queue u_commit_queue (
    .clk_i, .rst_ni,
    .push_i       (commit_push),
    .pop_i        (commit_pop),
    .wptr_i       (commit_wptr),
    .rptr_i       (commit_rptr),
    .entry_i      (spec_head),
    .page_off_i,
    .head_valid_o (head_valid),
    .match_o      (commit_match),
    .mem_index_o, .mem_tag_o, .mem_wdata_o, .mem_be_o, .mem_size_o
  );

  // a load has to wait if either queue still holds a store in the same double word
  assign page_match_o = spec_match | commit_match;

endmodule

// ==== tb_store_buffer.sv ====
// store buffer testbench
// random stores, commits, flushes and grants checked against a two-list model

`include "sb_defs.svh"

module tb_store_buffer;

  import sb_pkg::*;

  // cycles of stimulus per test, drains come on top and stay short
  localparam int unsigned len_reset   = 10;
  localparam int unsigned len_traffic = 400;
  localparam int unsigned len_flush   = 300;
  localparam int unsigned len_full    = 100;
  localparam int unsigned len_match   = 300;
  localparam int unsigned len_stall   = 150;
  localparam int unsigned len_total   = len_reset + len_traffic + len_flush + len_full +
                                        len_match + len_stall;

  logic                    clk_i, rst_ni, valid_i, commit_i, flush_i, stall_i;
  logic                    valid_nf_i, mem_gnt_i, ready_o, commit_ready_o;
  logic                    no_st_pending_o, empty_o, page_match_o, mem_req_o;
  sb_paddr_u               paddr_i;
  logic [`SB_XLEN-1:0]     data_i, mem_wdata_o;
  logic [be_w-1:0]         be_i, mem_be_o;
  logic [1:0]              size_i, mem_size_o;
  logic [page_off_w-1:0]   page_off_i;
  logic [`SB_INDEX_W-1:0]  mem_index_o;
  logic [`SB_TAG_W-1:0]    mem_tag_o;

  // model of both queues, oldest store at the front
  sb_entry_t spec_m[$];
  sb_entry_t commit_m[$];
  int        errors = 0;
  int        checks = 0;
  int        writes = 0;
  int        tests_done = 0;

  store_buffer DUT (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : watchdog
    repeat (4 * len_total) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a test did not finish", 4 * len_total);
    $display("*** FAILED ***");
    $finish;
  end

  // ----------------------------------------------------------------------
  // reference model and compare tasks
  // ----------------------------------------------------------------------
  // a load waits if any buffered store, or the one being written, hits address bits 11 to 3
  function automatic logic ref_match(logic [page_off_w-1:0] off, sb_paddr_u in_addr,
                                     logic in_valid);
    logic hit;
    hit = in_valid && (in_addr.page.page_off[11:3] == off[11:3]);
    foreach (spec_m[i]) hit |= spec_m[i].addr.page.page_off[11:3] == off[11:3];
    foreach (commit_m[i]) hit |= commit_m[i].addr.page.page_off[11:3] == off[11:3];
    return hit;
  endfunction

  function automatic void report_value(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("[ERROR] %s: got %h, expected %h", name, got, exp);
  endfunction

  task automatic check_addr(string name, sb_paddr_u got, sb_paddr_u exp);
    checks++;
    if (got !== exp) report_value(name, 64'(got), 64'(exp));
  endtask

  task automatic check_payload(logic [`SB_XLEN-1:0] data, logic [be_w-1:0] be,
                               logic [1:0] size, sb_entry_t exp);
    checks++;
    if (data !== exp.data) report_value("mem_wdata_o", data, exp.data);
    if (be !== exp.be) report_value("mem_be_o", 64'(be), 64'(exp.be));
    if (size !== exp.size) report_value("mem_size_o", 64'(size), 64'(exp.size));
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) report_value(name, 64'(got), 64'(exp));
  endtask

  // mid-cycle every input and output is settled, the model then steps over the next edge
  always @(negedge clk_i) begin : compare
    sb_entry_t head;
    sb_entry_t incoming;
    sb_paddr_u got_addr;
    int        spec_next;
    if (rst_ni) begin
      spec_next = flush_i ? 0 : int'(spec_m.size()) + int'(valid_i) - int'(commit_i);
      check_flag("ready_o", ready_o, commit_i || spec_next < `SB_DEPTH_SPEC);
      check_flag("commit_ready_o", commit_ready_o, commit_m.size() < `SB_DEPTH_COMMIT);
      check_flag("no_st_pending_o", no_st_pending_o, commit_m.size() == 0);
      check_flag("empty_o", empty_o, spec_m.size() == 0 && commit_m.size() == 0);
      check_flag("mem_req_o", mem_req_o, commit_m.size() != 0 && !stall_i);
      check_flag("page_match_o", page_match_o, ref_match(page_off_i, paddr_i, valid_nf_i));
      if (mem_req_o && mem_gnt_i) begin
        if (commit_m.size() == 0) begin
          errors++;
          $display("cache write granted while no committed store is left");
        end else begin
          head = commit_m.pop_front();
          got_addr.cache.tag   = mem_tag_o;
          got_addr.cache.index = mem_index_o;
          check_addr("mem_tag_o/mem_index_o", got_addr, head.addr);
          check_payload(mem_wdata_o, mem_be_o, mem_size_o, head);
          writes++;
        end
      end
      if (flush_i) spec_m.delete();
      if (commit_i) commit_m.push_back(spec_m.pop_front());
      if (valid_i && !flush_i) begin
        incoming = '{addr: paddr_i, data: data_i, be: be_i, size: size_i, valid: 1'b1};
        spec_m.push_back(incoming);
      end
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  // one cycle of traffic, percentages per strobe, legality taken from the model
  task automatic drive_random(int unsigned p_store, int unsigned p_commit,
                              int unsigned p_flush, int unsigned p_gnt);
    @(posedge clk_i);
    #10;
    flush_i  = ($urandom % 100) < p_flush;
    commit_i = !flush_i && spec_m.size() > 0 && commit_m.size() < `SB_DEPTH_COMMIT &&
               ($urandom % 100) < p_commit;
    valid_i  = !flush_i && (spec_m.size() < `SB_DEPTH_SPEC || commit_i) &&
               ($urandom % 100) < p_store;
    paddr_i.page.page_num = page_num_w'($urandom);
    paddr_i.page.page_off = page_off_w'($urandom);
    data_i     = {$urandom, $urandom};
    be_i       = be_w'($urandom);
    size_i     = 2'($urandom);
    mem_gnt_i  = ($urandom % 100) < p_gnt;
    valid_nf_i = 1'($urandom);
    // aim the load at a buffered store now and then so that hits are common
    page_off_i = page_off_w'($urandom);
    if (spec_m.size() > 0 && $urandom % 2 == 1) begin
      page_off_i = spec_m[$urandom % spec_m.size()].addr.page.page_off;
    end else if (commit_m.size() > 0 && $urandom % 2 == 1) begin
      page_off_i = commit_m[$urandom % commit_m.size()].addr.page.page_off;
    end
  endtask

  // grant until the commit queue is empty, the watchdog bounds the wait
  task automatic drain(int unsigned p_gnt);
    while (commit_m.size() != 0 || !no_st_pending_o) begin
      drive_random(0, 0, 0, p_gnt);
    end
  endtask

  task automatic finish_test(string name);
    tests_done++;
    $display("test %0d (%s) finished, %0d errors so far", tests_done, name, errors);
  endtask

  initial begin : main
    void'($urandom(32'hf047));
    rst_ni     = 1'b0;
    valid_i    = 1'b0;
    commit_i   = 1'b0;
    flush_i    = 1'b0;
    stall_i    = 1'b0;
    paddr_i    = '0;
    data_i     = '0;
    be_i       = '0;
    size_i     = '0;
    page_off_i = '0;
    valid_nf_i = 1'b0;
    mem_gnt_i  = 1'b0;
    repeat (len_reset) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b1);
    check_flag("commit_ready_o", commit_ready_o, 1'b1);
    check_flag("no_st_pending_o", no_st_pending_o, 1'b1);
    check_flag("empty_o", empty_o, 1'b1);
    check_flag("mem_req_o", mem_req_o, 1'b0);
    finish_test("reset state");
    repeat (len_traffic) drive_random(60, 50, 0, 40);
    drain(40);
    finish_test("commit and drain");
    repeat (len_flush) drive_random(60, 30, 15, 40);
    drain(40);
    finish_test("flush");
    // fill the speculative queue, then the commit queue with grants held low
    repeat (len_full / 2) drive_random(100, 0, 0, 0);
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b0);
    repeat (len_full / 2) drive_random(0, 100, 0, 0);
    @(negedge clk_i);
    check_flag("commit_ready_o", commit_ready_o, 1'b0);
    drain(50);
    finish_test("back-pressure");
    repeat (len_match) drive_random(40, 30, 5, 30);
    drive_random(0, 0, 100, 50);
    drain(50);
    drive_random(0, 0, 0, 0);
    valid_nf_i = 1'b0;
    @(negedge clk_i);
    check_flag("page_match_o", page_match_o, 1'b0);
    finish_test("page offset match");
    drive_random(0, 0, 0, 0);
    stall_i = 1'b1;
    repeat (len_stall) drive_random(50, 50, 5, 50);
    drive_random(0, 0, 0, 0);
    stall_i = 1'b0;
    drain(50);
    finish_test("stall");
    errors += int'(DUT.u_checker.fail_cnt);
    $display("%0d tests, %0d checks, %0d writes, %0d errors",
             tests_done, checks, writes, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
